/* include/olb_macros.svh */
// Width, lane, neuron, depth, junction and ideal-output delay macros for the output layer
`ifndef OLB_MACROS_SVH
`define OLB_MACROS_SVH

// Fixed point format, 1 sign + 5 integer + 10 fraction bits
`define OLB_INT_BITS 5
`define OLB_FRAC_BITS 10
`define OLB_WIDTH (1 + `OLB_INT_BITS + `OLB_FRAC_BITS) // 16 bits per sample

// Parallelism and layer size
`define OLB_Z 2 // Lanes (neurons) handled per clock
`define OLB_P 8 // Neurons in the output layer

// Each bank holds one junction worth of deltas, Z per word
`define OLB_DEPTH (`OLB_P / `OLB_Z)

// Junction length, two extra cycles beyond the data words
`define OLB_CPC (`OLB_DEPTH + 2)

// Network depth
`define OLB_LAYERS 3

// Ideal outputs travel alongside the feed-forward wave through the earlier layers
`define OLB_Y_DELAY (`OLB_CPC * (`OLB_LAYERS - 1))

`endif

/* source/fixed_point_pkg.sv */
// Fixed-point sample type, lane vector, ideal-output vector and fixed-point constants
`include "olb_macros.svh"

package fixed_point_pkg;

	// One signed sample, sign + int + frac
	typedef logic signed [`OLB_WIDTH-1:0] fxp_t;

	// Z samples side by side, lane 0 in the low bits
	typedef fxp_t [`OLB_Z-1:0] lane_vec_t;

	// One ideal output bit per lane, read as 0.0 or 1.0
	typedef logic [`OLB_Z-1:0] ideal_vec_t;

	// 1.0 in fixed point
	localparam fxp_t fxp_one = fxp_t'(1 << `OLB_FRAC_BITS);

	// Most negative representable value, floor of the cost term
	localparam fxp_t fxp_min = {1'b1, {(`OLB_WIDTH-1){1'b0}}};

endpackage

/* source/junction_pkg.sv */
// Cycle index, bank, address, FSM state and delta memory command types
`include "olb_macros.svh"

package junction_pkg;

	// Position within a junction, 0 .. CPC-1
	typedef logic [$clog2(`OLB_CPC)-1:0] cycle_idx_t;

	// Selects one of the two delta banks
	typedef logic bank_t;

	// Word address inside a bank, 0 .. DEPTH-1
	typedef logic [$clog2(`OLB_DEPTH)-1:0] mem_addr_t;

	// Delta memory FSM states
	typedef enum logic {
		FILL = 1'b0, // No bank holds a finished junction yet
		RUN = 1'b1 // Read bank holds the previous junction's deltas
	} olb_state_t;

	// One clock's worth of delta memory control
	typedef struct packed {
		logic we; // Write delta this cycle
		bank_t wr_bank; // Bank being filled
		mem_addr_t wr_addr; // Word written
		logic re; // Read toward previous layer this cycle
		mem_addr_t rd_addr; // Word read, bank is the other one
	} mem_cmd_t;

endpackage

/* source/junction_counter.sv */
// Junction cycle counter with registered index and junction-end pulse
`include "olb_macros.svh"

module junction_counter (
	input logic clk,
	input logic rst_n_i,
	output junction_pkg::cycle_idx_t cycle_index_o, // Current cycle within junction
	output logic cycle_clk_o // High in the last cycle of each junction
);

	// Last cycle of a junction
	localparam junction_pkg::cycle_idx_t last_idx = junction_pkg::cycle_idx_t'(`OLB_CPC - 1);

	junction_pkg::cycle_idx_t idx_next; // Index for the coming cycle

	// Wrap modulo CPC
	always_comb begin
		if (cycle_index_o == last_idx) begin
			idx_next = '0;
		end else begin
			idx_next = cycle_index_o + 1'b1;
		end
	end

	// Index and pulse come out of flops, so the whole layer sees them at once
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cycle_index_o <= '0; // First cycle out of reset is index 0
			cycle_clk_o <= 1'b0;
		end else begin
			cycle_index_o <= idx_next;
			cycle_clk_o <= (idx_next == last_idx); // Pulse lines up with the last index
		end
	end

endmodule

/* source/delta_mem_fsm.sv */
// Delta memory FSM with ping-pong bank pointer and write/read command generation
`include "olb_macros.svh"

module delta_mem_fsm (
	input logic clk,
	input logic rst_n_i,
	input junction_pkg::cycle_idx_t cycle_index_i, // From junction counter
	input logic cycle_clk_i, // Junction end
	output junction_pkg::mem_cmd_t mem_cmd_o // To delta bank pair
);

	junction_pkg::olb_state_t state_q; // FILL until first junction completes
	junction_pkg::bank_t wr_bank_q; // Bank filled in this junction
	logic data_cycle; // Index points at a data word

	// Only the first DEPTH cycles of a junction carry deltas
	assign data_cycle = (cycle_index_i < `OLB_DEPTH);

	// State and bank pointer move only at junction end
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= junction_pkg::FILL;
			wr_bank_q <= 1'b0;
		end else if (cycle_clk_i) begin
			wr_bank_q <= ~wr_bank_q; // Swap roles of the two banks
			case (state_q)
				junction_pkg::FILL: state_q <= junction_pkg::RUN; // Bank now holds a junction
				junction_pkg::RUN: state_q <= junction_pkg::RUN;
				default: state_q <= junction_pkg::FILL;
			endcase
		end
	end

	// Command is a pure decode of index and state
	always_comb begin
		mem_cmd_o.we = data_cycle;
		mem_cmd_o.wr_bank = wr_bank_q;
		mem_cmd_o.wr_addr = junction_pkg::mem_addr_t'(cycle_index_i); // Word k at index k
		// Previous junction is replayed in the same order it was written
		mem_cmd_o.re = data_cycle && (state_q == junction_pkg::RUN);
		mem_cmd_o.rd_addr = junction_pkg::mem_addr_t'(cycle_index_i);
	end

endmodule

/* source/ideal_output_delay.sv */
// Shift register delaying ideal outputs by the latency of the earlier layers
`include "olb_macros.svh"

module ideal_output_delay (
	input logic clk,
	input logic rst_n_i,
	input fixed_point_pkg::ideal_vec_t y_i, // Ideal outputs entering with the input layer
	output fixed_point_pkg::ideal_vec_t y_l_o // Same bits, aligned with the final activations
);

	// Stage 0 takes y_i, last stage drives the output
	fixed_point_pkg::ideal_vec_t [`OLB_Y_DELAY-1:0] sr_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sr_q <= '0; // Outputs read as 0 until the pipe fills
		end else begin
			sr_q <= {sr_q[`OLB_Y_DELAY-2:0], y_i}; // One stage per clock
		end
	end

	// Oldest entry, Y_DELAY cycles old
	assign y_l_o = sr_q[`OLB_Y_DELAY-1];

endmodule

/* source/cost_delta_unit.sv */
// Per-lane cross-entropy delta, activation minus ideal output with saturation
`include "olb_macros.svh"

module cost_delta_unit (
	input fixed_point_pkg::lane_vec_t act_l_i, // Final activations
	input fixed_point_pkg::ideal_vec_t y_l_i, // Delayed ideal bits
	output fixed_point_pkg::lane_vec_t delta_o // a - y per lane
);

	genvar gv_i;
	generate
		for (gv_i = 0; gv_i < `OLB_Z; gv_i = gv_i + 1) begin : g_lane
			fixed_point_pkg::fxp_t y_fxp; // Ideal bit as 0.0 or 1.0
			logic signed [`OLB_WIDTH:0] diff; // One guard bit for underflow

			assign y_fxp = y_l_i[gv_i] ? fixed_point_pkg::fxp_one : '0;

			// Sign extend activation, ideal value is never negative
			assign diff = {act_l_i[gv_i][`OLB_WIDTH-1], act_l_i[gv_i]} - {1'b0, y_fxp};

			// Guard and sign bits disagree only when the result fell below the minimum
			always_comb begin
				if (diff[`OLB_WIDTH] != diff[`OLB_WIDTH-1]) begin
					delta_o[gv_i] = fixed_point_pkg::fxp_min; // Clamp
				end else begin
					delta_o[gv_i] = diff[`OLB_WIDTH-1:0];
				end
			end
		end
	endgenerate

endmodule

/* source/delta_bank_pair.sv */
// Ping-pong delta memory banks with registered read port and valid flag
`include "olb_macros.svh"

module delta_bank_pair (
	input logic clk,
	input logic rst_n_i,
	input junction_pkg::mem_cmd_t mem_cmd_i, // Write and read control from FSM
	input fixed_point_pkg::lane_vec_t delta_i, // Deltas from cost unit
	output fixed_point_pkg::lane_vec_t delta_l_o, // Deltas toward previous layer
	output logic delta_valid_o // delta_l_o carries a fresh word
);

	// Two banks of DEPTH words, each word one lane vector
	fixed_point_pkg::lane_vec_t bank_mem [0:1][0:`OLB_DEPTH-1];

	junction_pkg::bank_t rd_bank; // Bank holding the finished junction

	// Always the bank not being written
	assign rd_bank = ~mem_cmd_i.wr_bank;

	// Write port
	always_ff @(posedge clk) begin
		if (mem_cmd_i.we) begin
			bank_mem[mem_cmd_i.wr_bank][mem_cmd_i.wr_addr] <= delta_i;
		end
	end

	// Read port, output holds between reads
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			delta_l_o <= '0;
			delta_valid_o <= 1'b0;
		end else begin
			delta_valid_o <= mem_cmd_i.re; // Valid follows the read by one cycle
			if (mem_cmd_i.re) begin
				delta_l_o <= bank_mem[rd_bank][mem_cmd_i.rd_addr];
			end
		end
	end

endmodule

/* source/output_layer_block.sv */
// Output layer block top level connecting timing, FSM, ideal-output delay, cost and delta banks
module output_layer_block (
	input logic clk,
	input logic rst_n_i,
	input fixed_point_pkg::lane_vec_t act_l_i, // Final activations, Z per clock
	input fixed_point_pkg::ideal_vec_t y_i, // Ideal outputs from network input
	output fixed_point_pkg::lane_vec_t delta_l_o, // Deltas toward previous layer
	output logic delta_valid_o,
	output fixed_point_pkg::ideal_vec_t y_l_o, // Delayed ideal outputs
	output junction_pkg::cycle_idx_t cycle_index_o,
	output logic cycle_clk_o
);

	junction_pkg::mem_cmd_t mem_cmd; // FSM to delta banks
	fixed_point_pkg::lane_vec_t delta; // Cost unit to bank write data

	// Junction timing, shared with the outputs
	junction_counter u_junction_counter (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.cycle_index_o(cycle_index_o),
		.cycle_clk_o(cycle_clk_o)
	);

	delta_mem_fsm u_delta_mem_fsm (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.cycle_index_i(cycle_index_o),
		.cycle_clk_i(cycle_clk_o),
		.mem_cmd_o(mem_cmd)
	);

	// Ideal bits catch up with the activations
	ideal_output_delay u_ideal_output_delay (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.y_i(y_i),
		.y_l_o(y_l_o)
	);

	cost_delta_unit u_cost_delta_unit (
		.act_l_i(act_l_i),
		.y_l_i(y_l_o),
		.delta_o(delta)
	);

	delta_bank_pair u_delta_bank_pair (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.mem_cmd_i(mem_cmd),
		.delta_i(delta),
		.delta_l_o(delta_l_o),
		.delta_valid_o(delta_valid_o)
	);

endmodule

/* sim/tb_output_layer_block.sv */
// Testbench for the output layer block with random stimulus, reference model and compare tasks
`include "olb_macros.svh"

module tb_output_layer_block;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int JUNCTIONS = 40; // Length of the random run
	localparam int RST_CYCLES = 4;
	localparam int TMO_LIMIT = JUNCTIONS * `OLB_CPC + RST_CYCLES + 50;
	localparam int FXP_ONE = 1 << `OLB_FRAC_BITS; // 1.0
	localparam int FXP_MIN = -(1 << (`OLB_WIDTH - 1)); // Most negative sample
	localparam int EXP_VALID = (JUNCTIONS - 1) * `OLB_DEPTH; // First junction only fills

	logic clk;
	logic rst_n_i;
	fixed_point_pkg::lane_vec_t act_l; // Activations into DUT
	fixed_point_pkg::ideal_vec_t y_in; // Undelayed ideal bits
	fixed_point_pkg::lane_vec_t delta_l;
	logic delta_valid;
	fixed_point_pkg::ideal_vec_t y_l;
	junction_pkg::cycle_idx_t cycle_index;
	logic cycle_clk;

	// Reference model state, all values as seen during the current cycle
	int m_idx; // Cycle index
	bit m_wr; // Bank filled this junction
	bit m_run; // Some bank holds a finished junction
	logic m_valid;
	fixed_point_pkg::lane_vec_t m_dout; // Held between reads
	fixed_point_pkg::lane_vec_t m_bank [0:1][0:`OLB_DEPTH-1];
	fixed_point_pkg::ideal_vec_t y_hist [$]; // Last Y_DELAY ideal inputs

	int valid_seen = 0;
	int clamp_seen = 0; // Lanes that hit the floor in the model
	int tmo_cnt = 0;

	output_layer_block UUT (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.act_l_i(act_l),
		.y_i(y_in),
		.delta_l_o(delta_l),
		.delta_valid_o(delta_valid),
		.y_l_o(y_l),
		.cycle_index_o(cycle_index),
		.cycle_clk_o(cycle_clk)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Message, then stop
	task automatic abort_run(string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_lanes(string name, fixed_point_pkg::lane_vec_t exp_v,
			fixed_point_pkg::lane_vec_t act_v);
		if (act_v !== exp_v) begin
			abort_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp_v, act_v));
		end
	endtask

	task automatic check_ideal(string name, fixed_point_pkg::ideal_vec_t exp_v,
			fixed_point_pkg::ideal_vec_t act_v);
		if (act_v !== exp_v) begin
			abort_run($sformatf("ERR t=%0t %s expected %b actual %b", $time, name, exp_v, act_v));
		end
	endtask

	task automatic check_index(string name, junction_pkg::cycle_idx_t exp_v,
			junction_pkg::cycle_idx_t act_v);
		if (act_v !== exp_v) begin
			abort_run($sformatf("ERR t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v));
		end
	endtask

	task automatic check_bit(string name, logic exp_v, logic act_v);
		if (act_v !== exp_v) begin
			abort_run($sformatf("ERR t=%0t %s expected %b actual %b", $time, name, exp_v, act_v));
		end
	endtask

	// Activation minus ideal value, before any clamp
	function automatic int sub_ideal(fixed_point_pkg::fxp_t a, logic y);
		return int'(a) - (y ? FXP_ONE : 0);
	endfunction

	// Floor at the most negative sample
	function automatic fixed_point_pkg::fxp_t clamp_low(int v);
		return (v < FXP_MIN) ? fixed_point_pkg::fxp_t'(FXP_MIN) : fixed_point_pkg::fxp_t'(v);
	endfunction

	// Ideal bits 12 cycles old, zero while history is short
	function automatic fixed_point_pkg::ideal_vec_t delayed_ideal();
		return (y_hist.size() == `OLB_Y_DELAY) ? y_hist[0] : '0;
	endfunction

	// New random inputs for the coming cycle
	task automatic drive_inputs();
		fixed_point_pkg::lane_vec_t a;
		for (int l = 0; l < `OLB_Z; l++) begin
			a[l] = fixed_point_pkg::fxp_t'($urandom);
			if (($urandom % 8) == 0) begin
				a[l] = fixed_point_pkg::fxp_t'(FXP_MIN + int'($urandom % 1024)); // Near floor
			end
		end
		act_l <= a;
		y_in <= fixed_point_pkg::ideal_vec_t'($urandom);
	endtask

	// Advance the model over one rising edge with the inputs of the cycle just ended
	task automatic model_step();
		junction_pkg::mem_addr_t addr;
		fixed_point_pkg::lane_vec_t wd;
		fixed_point_pkg::ideal_vec_t y_now;
		int raw;
		addr = junction_pkg::mem_addr_t'(m_idx);
		y_now = delayed_ideal();
		m_valid = 1'b0;
		if (m_idx < `OLB_DEPTH) begin
			if (m_run) begin
				m_dout = m_bank[~m_wr][addr]; // Previous junction, same word order
				m_valid = 1'b1;
			end
			for (int l = 0; l < `OLB_Z; l++) begin
				raw = sub_ideal(act_l[l], y_now[l]);
				if (raw < FXP_MIN) begin
					clamp_seen++;
				end
				wd[l] = clamp_low(raw);
			end
			m_bank[m_wr][addr] = wd;
		end
		if (m_idx == `OLB_CPC - 1) begin // Junction end
			m_wr = ~m_wr;
			m_run = 1'b1;
		end
		y_hist.push_back(y_in);
		if (y_hist.size() > `OLB_Y_DELAY) begin
			void'(y_hist.pop_front());
		end
		m_idx = (m_idx == `OLB_CPC - 1) ? 0 : m_idx + 1;
	endtask

	// Everything reads zero while reset is held
	task automatic check_reset_state();
		check_index("cycle_index_o", '0, cycle_index);
		check_bit("cycle_clk_o", 1'b0, cycle_clk);
		check_ideal("y_l_o", '0, y_l);
		check_bit("delta_valid_o", 1'b0, delta_valid);
		check_lanes("delta_l_o", '0, delta_l);
	endtask

	task automatic check_outputs();
		check_index("cycle_index_o", junction_pkg::cycle_idx_t'(m_idx), cycle_index);
		check_bit("cycle_clk_o", logic'(m_idx == `OLB_CPC - 1), cycle_clk); // Last index only
		check_ideal("y_l_o", delayed_ideal(), y_l);
		check_bit("delta_valid_o", m_valid, delta_valid);
		check_lanes("delta_l_o", m_dout, delta_l); // Also checks the hold between reads
		if (delta_valid) begin
			valid_seen++;
		end
	endtask

	// Run length guard
	always @(posedge clk) begin
		tmo_cnt = tmo_cnt + 1;
		if (tmo_cnt > TMO_LIMIT) begin
			abort_run($sformatf("Timeout: run still going after %0d cycles", TMO_LIMIT));
		end
	end

	initial begin
		void'($urandom(54817)); // Seed the stimulus stream once
		rst_n_i = 1'b0;
		act_l = '0;
		y_in = '0;
		m_idx = 0; // Model starts in its reset state
		m_wr = 1'b0;
		m_run = 1'b0;
		m_valid = 1'b0;
		m_dout = '0;
		// Reset spans four rising edges
		repeat (RST_CYCLES - 1) begin
			@(negedge clk);
			check_reset_state();
		end
		@(posedge clk);
		rst_n_i <= 1'b1;
		drive_inputs();
		// Check mid cycle, step model and drive on the rising edge
		for (int n = 0; n < JUNCTIONS * `OLB_CPC; n++) begin
			@(negedge clk);
			check_outputs();
			@(posedge clk);
			model_step();
			drive_inputs();
		end
		if (valid_seen != EXP_VALID || clamp_seen == 0) begin
			abort_run($sformatf("Run incomplete: %0d of %0d deltas read, %0d clamped lanes",
				valid_seen, EXP_VALID, clamp_seen));
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

/* output_layer_block.f */
+incdir+include
source/fixed_point_pkg.sv
source/junction_pkg.sv
source/junction_counter.sv
source/delta_mem_fsm.sv
source/ideal_output_delay.sv
source/cost_delta_unit.sv
source/delta_bank_pair.sv
source/output_layer_block.sv
sim/tb_output_layer_block.sv

/* Makefile */
# Verilator build and run for the output layer block

VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_output_layer_block
FILELIST  = output_layer_block.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = all tests passed

# Everything the binary depends on
SRCS = $(wildcard source/*.sv) $(wildcard sim/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is shown, status comes from the pass message search
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
